// File: logic/core_pkg.sv
package core_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int num_regs       = 32;
  localparam int imm_width      = 16;
  localparam int alu_op_width   = 4;

  // opcodes
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_andi  = 6'h0c;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lui   = 6'h0f;

  // register format function codes
  localparam logic [5:0] fn_sll = 6'h00;
  localparam logic [5:0] fn_srl = 6'h02;
  localparam logic [5:0] fn_add = 6'h20;
  localparam logic [5:0] fn_sub = 6'h22;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or  = 6'h25;
  localparam logic [5:0] fn_xor = 6'h26;
  localparam logic [5:0] fn_slt = 6'h2a;

  // alu operations
  localparam logic [alu_op_width-1:0] alu_add = 4'd0;
  localparam logic [alu_op_width-1:0] alu_sub = 4'd1;
  localparam logic [alu_op_width-1:0] alu_and = 4'd2;
  localparam logic [alu_op_width-1:0] alu_or  = 4'd3;
  localparam logic [alu_op_width-1:0] alu_xor = 4'd4;
  localparam logic [alu_op_width-1:0] alu_slt = 4'd5;
  localparam logic [alu_op_width-1:0] alu_sll = 4'd6;
  localparam logic [alu_op_width-1:0] alu_srl = 4'd7;
  localparam logic [alu_op_width-1:0] alu_lui = 4'd8;

  // operand source selects
  localparam logic [1:0] fwd_stored = 2'd0;
  localparam logic [1:0] fwd_lane0  = 2'd1;
  localparam logic [1:0] fwd_lane1  = 2'd2;

  ////////////////////
  // instruction word
  ////////////////////

  typedef union packed {
    struct packed {
      logic [5:0]                opcode;
      logic [reg_addr_width-1:0] rs;
      logic [reg_addr_width-1:0] rt;
      logic [reg_addr_width-1:0] rd;
      logic [reg_addr_width-1:0] shamt;
      logic [5:0]                funct;
    } r;
    struct packed {
      logic [5:0]                opcode;
      logic [reg_addr_width-1:0] rs;
      logic [reg_addr_width-1:0] rt;
      logic [imm_width-1:0]      imm;
    } i;
  } instr_t;

endpackage

// File: logic/lane_decoder.sv
`timescale 1ns/1ps

module lane_decoder (
  input  core_pkg::instr_t                         instr,
  output logic [core_pkg::reg_addr_width-1:0]      rs,
  output logic [core_pkg::reg_addr_width-1:0]      rt,
  output logic [core_pkg::reg_addr_width-1:0]      dest,
  output logic [core_pkg::alu_op_width-1:0]        alu_op,
  output logic                                     use_imm,
  output logic [core_pkg::imm_width-1:0]           imm,
  output logic [core_pkg::reg_addr_width-1:0]      shamt,
  output logic                                     writes
);

  logic known;
  logic is_rtype;

  always_comb begin
    known   = 1'b1;
    use_imm = 1'b1;
    alu_op  = core_pkg::alu_add;
    case (instr.r.opcode)
      core_pkg::op_rtype: begin
        use_imm = 1'b0;
        case (instr.r.funct)
          core_pkg::fn_add: alu_op = core_pkg::alu_add;
          core_pkg::fn_sub: alu_op = core_pkg::alu_sub;
          core_pkg::fn_and: alu_op = core_pkg::alu_and;
          core_pkg::fn_or:  alu_op = core_pkg::alu_or;
          core_pkg::fn_xor: alu_op = core_pkg::alu_xor;
          core_pkg::fn_slt: alu_op = core_pkg::alu_slt;
          core_pkg::fn_sll: alu_op = core_pkg::alu_sll;
          core_pkg::fn_srl: alu_op = core_pkg::alu_srl;
          default:          known  = 1'b0;
        endcase
      end
      core_pkg::op_addi: alu_op = core_pkg::alu_add;
      core_pkg::op_andi: alu_op = core_pkg::alu_and;
      core_pkg::op_ori:  alu_op = core_pkg::alu_or;
      core_pkg::op_lui:  alu_op = core_pkg::alu_lui;
      default:           known  = 1'b0;
    endcase
  end

  assign is_rtype = (instr.r.opcode == core_pkg::op_rtype);

  // source fields sit in the same place in both views
  assign rs    = instr.i.rs;
  assign rt    = instr.i.rt;
  assign imm   = instr.i.imm;
  assign shamt = instr.r.shamt;
  assign dest  = is_rtype ? instr.r.rd : instr.i.rt;

  // unknown encodings and r0 targets are nops
  assign writes = known && (dest != '0);

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic [core_pkg::reg_addr_width-1:0] raddr0a,
  input  logic [core_pkg::reg_addr_width-1:0] raddr0b,
  input  logic [core_pkg::reg_addr_width-1:0] raddr1a,
  input  logic [core_pkg::reg_addr_width-1:0] raddr1b,
  output logic [core_pkg::data_width-1:0]     rdata0a,
  output logic [core_pkg::data_width-1:0]     rdata0b,
  output logic [core_pkg::data_width-1:0]     rdata1a,
  output logic [core_pkg::data_width-1:0]     rdata1b,
  input  logic                                we0,
  input  logic                                we1,
  input  logic [core_pkg::reg_addr_width-1:0] waddr0,
  input  logic [core_pkg::reg_addr_width-1:0] waddr1,
  input  logic [core_pkg::data_width-1:0]     wdata0,
  input  logic [core_pkg::data_width-1:0]     wdata1
);

  // r0 has no storage
  logic [core_pkg::data_width-1:0] regs [1:core_pkg::num_regs-1];

  assign rdata0a = (raddr0a == '0) ? '0 : regs[raddr0a];
  assign rdata0b = (raddr0b == '0) ? '0 : regs[raddr0b];
  assign rdata1a = (raddr1a == '0) ? '0 : regs[raddr1a];
  assign rdata1b = (raddr1b == '0) ? '0 : regs[raddr1b];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int idx = 1; idx < core_pkg::num_regs; idx++) begin
        regs[idx] <= '0;
      end
    end else begin
      // port 1 is the younger lane and wins a clash
      if (we0 && waddr0 != '0 && !(we1 && waddr1 == waddr0)) begin
        regs[waddr0] <= wdata0;
      end
      if (we1 && waddr1 != '0) begin
        regs[waddr1] <= wdata1;
      end
    end
  end

  // decoders must have dropped r0 targets upstream
  a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
    !(we0 && waddr0 == '0) && !(we1 && waddr1 == '0));

endmodule

// File: logic/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit (
  input  logic [core_pkg::reg_addr_width-1:0] ex_rs0,
  input  logic [core_pkg::reg_addr_width-1:0] ex_rt0,
  input  logic [core_pkg::reg_addr_width-1:0] ex_rs1,
  input  logic [core_pkg::reg_addr_width-1:0] ex_rt1,
  input  logic                                wb_we0,
  input  logic                                wb_we1,
  input  logic [core_pkg::reg_addr_width-1:0] wb_reg0,
  input  logic [core_pkg::reg_addr_width-1:0] wb_reg1,
  output logic [1:0]                          sel_rs0,
  output logic [1:0]                          sel_rt0,
  output logic [1:0]                          sel_rs1,
  output logic [1:0]                          sel_rt1
);

  // lane 1 first, same priority as the register file
  function automatic logic [1:0] pick_source(
    input logic [core_pkg::reg_addr_width-1:0] src,
    input logic                                we0,
    input logic [core_pkg::reg_addr_width-1:0] reg0,
    input logic                                we1,
    input logic [core_pkg::reg_addr_width-1:0] reg1
  );
    logic [1:0] sel;
    sel = core_pkg::fwd_stored;
    if (src != '0) begin
      if (we1 && reg1 == src) begin
        sel = core_pkg::fwd_lane1;
      end else if (we0 && reg0 == src) begin
        sel = core_pkg::fwd_lane0;
      end
    end
    return sel;
  endfunction

  assign sel_rs0 = pick_source(ex_rs0, wb_we0, wb_reg0, wb_we1, wb_reg1);
  assign sel_rt0 = pick_source(ex_rt0, wb_we0, wb_reg0, wb_we1, wb_reg1);
  assign sel_rs1 = pick_source(ex_rs1, wb_we0, wb_reg0, wb_we1, wb_reg1);
  assign sel_rt1 = pick_source(ex_rt1, wb_we0, wb_reg0, wb_we1, wb_reg1);

endmodule

// File: logic/execute_lane.sv
`timescale 1ns/1ps

module execute_lane (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic [core_pkg::data_width-1:0]     rs_val,
  input  logic [core_pkg::data_width-1:0]     rt_val,
  input  logic [1:0]                          sel_rs,
  input  logic [1:0]                          sel_rt,
  input  logic [core_pkg::data_width-1:0]     fwd0,
  input  logic [core_pkg::data_width-1:0]     fwd1,
  input  logic [core_pkg::alu_op_width-1:0]   alu_op,
  input  logic                                use_imm,
  input  logic [core_pkg::imm_width-1:0]      imm,
  input  logic [core_pkg::reg_addr_width-1:0] shamt,
  input  logic                                we,
  input  logic [core_pkg::reg_addr_width-1:0] dest,
  output logic [core_pkg::data_width-1:0]     result,
  output logic                                wb_valid,
  output logic [core_pkg::reg_addr_width-1:0] wb_reg,
  output logic [core_pkg::data_width-1:0]     wb_data
);

  localparam int pad_width = core_pkg::data_width - core_pkg::imm_width;

  logic [core_pkg::data_width-1:0] op_a;
  logic [core_pkg::data_width-1:0] rt_fwd;
  logic [core_pkg::data_width-1:0] op_b;
  logic [core_pkg::data_width-1:0] ext_imm;
  logic                            less;

  function automatic logic [core_pkg::data_width-1:0] operand(
    input logic [1:0]                      sel,
    input logic [core_pkg::data_width-1:0] stored,
    input logic [core_pkg::data_width-1:0] lane0,
    input logic [core_pkg::data_width-1:0] lane1
  );
    case (sel)
      core_pkg::fwd_lane0: return lane0;
      core_pkg::fwd_lane1: return lane1;
      default:             return stored;
    endcase
  endfunction

  ////////////////////
  // operands
  ////////////////////

  assign op_a    = operand(sel_rs, rs_val, fwd0, fwd1);
  assign rt_fwd  = operand(sel_rt, rt_val, fwd0, fwd1);
  // immediates are zero extended
  assign ext_imm = {{pad_width{1'b0}}, imm};
  assign op_b    = use_imm ? ext_imm : rt_fwd;
  assign less    = $signed(op_a) < $signed(op_b);

  ////////////////////
  // alu
  ////////////////////

  always_comb begin
    case (alu_op)
      core_pkg::alu_add: result = op_a + op_b;
      core_pkg::alu_sub: result = op_a - op_b;
      core_pkg::alu_and: result = op_a & op_b;
      core_pkg::alu_or:  result = op_a | op_b;
      core_pkg::alu_xor: result = op_a ^ op_b;
      core_pkg::alu_slt: result = {{(core_pkg::data_width-1){1'b0}}, less};
      // shifts act on rt by shamt
      core_pkg::alu_sll: result = op_b << shamt;
      core_pkg::alu_srl: result = op_b >> shamt;
      core_pkg::alu_lui: result = {imm, {pad_width{1'b0}}};
      default:           result = '0;
    endcase
  end

  // write-back register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= we;
    end
  end

  always_ff @(posedge clk) begin
    wb_reg  <= dest;
    wb_data <= result;
  end

endmodule

// File: logic/dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                issue,
  input  core_pkg::instr_t                    instr0,
  input  core_pkg::instr_t                    instr1,
  output logic                                wb0_valid,
  output logic                                wb1_valid,
  output logic [core_pkg::reg_addr_width-1:0] wb0_reg,
  output logic [core_pkg::reg_addr_width-1:0] wb1_reg,
  output logic [core_pkg::data_width-1:0]     wb0_data,
  output logic [core_pkg::data_width-1:0]     wb1_data
);

  // decode stage
  logic                                dec_valid;
  core_pkg::instr_t                    dec_instr [2];
  logic [core_pkg::reg_addr_width-1:0] dec_rs [2];
  logic [core_pkg::reg_addr_width-1:0] dec_rt [2];
  logic [core_pkg::reg_addr_width-1:0] dec_dest [2];
  logic [core_pkg::alu_op_width-1:0]   dec_alu_op [2];
  logic                                dec_use_imm [2];
  logic [core_pkg::imm_width-1:0]      dec_imm [2];
  logic [core_pkg::reg_addr_width-1:0] dec_shamt [2];
  logic                                dec_writes [2];
  logic [core_pkg::data_width-1:0]     rd_rs [2];
  logic [core_pkg::data_width-1:0]     rd_rt [2];

  // execute stage
  logic                                ex_we [2];
  logic [core_pkg::data_width-1:0]     ex_rs_val [2];
  logic [core_pkg::data_width-1:0]     ex_rt_val [2];
  logic [core_pkg::reg_addr_width-1:0] ex_rs [2];
  logic [core_pkg::reg_addr_width-1:0] ex_rt [2];
  logic [core_pkg::alu_op_width-1:0]   ex_alu_op [2];
  logic                                ex_use_imm [2];
  logic [core_pkg::imm_width-1:0]      ex_imm [2];
  logic [core_pkg::reg_addr_width-1:0] ex_shamt [2];
  logic [core_pkg::reg_addr_width-1:0] ex_dest [2];
  logic [1:0]                          sel_rs [2];
  logic [1:0]                          sel_rt [2];
  logic [core_pkg::data_width-1:0]     alu_result [2];

  // write-back stage
  logic                                wb_valid [2];
  logic [core_pkg::reg_addr_width-1:0] wb_reg [2];
  logic [core_pkg::data_width-1:0]     wb_data [2];

  ////////////////////
  // pipeline registers
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
      ex_we[0]  <= 1'b0;
      ex_we[1]  <= 1'b0;
    end else begin
      dec_valid <= issue;
      ex_we[0]  <= dec_valid && dec_writes[0];
      ex_we[1]  <= dec_valid && dec_writes[1];
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      dec_instr[0] <= instr0;
      dec_instr[1] <= instr1;
    end
    for (int ln = 0; ln < 2; ln++) begin
      ex_rs_val[ln]  <= rd_rs[ln];
      ex_rt_val[ln]  <= rd_rt[ln];
      ex_rs[ln]      <= dec_rs[ln];
      ex_rt[ln]      <= dec_rt[ln];
      ex_alu_op[ln]  <= dec_alu_op[ln];
      ex_use_imm[ln] <= dec_use_imm[ln];
      ex_imm[ln]     <= dec_imm[ln];
      ex_shamt[ln]   <= dec_shamt[ln];
      ex_dest[ln]    <= dec_dest[ln];
    end
  end

  ////////////////////
  // shared units
  ////////////////////

  // both lanes read the state from before the pair
  register_file i_register_file (
    .clk     (clk),
    .arst_n  (arst_n),
    .raddr0a (dec_rs[0]),
    .raddr0b (dec_rt[0]),
    .raddr1a (dec_rs[1]),
    .raddr1b (dec_rt[1]),
    .rdata0a (rd_rs[0]),
    .rdata0b (rd_rt[0]),
    .rdata1a (rd_rs[1]),
    .rdata1b (rd_rt[1]),
    .we0     (ex_we[0]),
    .we1     (ex_we[1]),
    .waddr0  (ex_dest[0]),
    .waddr1  (ex_dest[1]),
    .wdata0  (alu_result[0]),
    .wdata1  (alu_result[1])
  );

  forwarding_unit i_forwarding_unit (
    .ex_rs0  (ex_rs[0]),
    .ex_rt0  (ex_rt[0]),
    .ex_rs1  (ex_rs[1]),
    .ex_rt1  (ex_rt[1]),
    .wb_we0  (wb_valid[0]),
    .wb_we1  (wb_valid[1]),
    .wb_reg0 (wb_reg[0]),
    .wb_reg1 (wb_reg[1]),
    .sel_rs0 (sel_rs[0]),
    .sel_rt0 (sel_rt[0]),
    .sel_rs1 (sel_rs[1]),
    .sel_rt1 (sel_rt[1])
  );

  for (genvar ln = 0; ln < 2; ln++) begin : g_lane
    lane_decoder i_lane_decoder (
      .instr   (dec_instr[ln]),
      .rs      (dec_rs[ln]),
      .rt      (dec_rt[ln]),
      .dest    (dec_dest[ln]),
      .alu_op  (dec_alu_op[ln]),
      .use_imm (dec_use_imm[ln]),
      .imm     (dec_imm[ln]),
      .shamt   (dec_shamt[ln]),
      .writes  (dec_writes[ln])
    );

    execute_lane i_execute_lane (
      .clk      (clk),
      .arst_n   (arst_n),
      .rs_val   (ex_rs_val[ln]),
      .rt_val   (ex_rt_val[ln]),
      .sel_rs   (sel_rs[ln]),
      .sel_rt   (sel_rt[ln]),
      .fwd0     (wb_data[0]),
      .fwd1     (wb_data[1]),
      .alu_op   (ex_alu_op[ln]),
      .use_imm  (ex_use_imm[ln]),
      .imm      (ex_imm[ln]),
      .shamt    (ex_shamt[ln]),
      .we       (ex_we[ln]),
      .dest     (ex_dest[ln]),
      .result   (alu_result[ln]),
      .wb_valid (wb_valid[ln]),
      .wb_reg   (wb_reg[ln]),
      .wb_data  (wb_data[ln])
    );
  end

  assign wb0_valid = wb_valid[0];
  assign wb1_valid = wb_valid[1];
  assign wb0_reg   = wb_reg[0];
  assign wb1_reg   = wb_reg[1];
  assign wb0_data  = wb_data[0];
  assign wb1_data  = wb_data[1];

  // an unknown strobe would poison every later stage
  a_issue_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(issue));

endmodule

// File: tb/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// architectural register state, r0 held at zero
logic [core_pkg::data_width-1:0] model_regs [core_pkg::num_regs];

function automatic core_pkg::instr_t encode_rtype(
  input logic [5:0]                          funct,
  input logic [core_pkg::reg_addr_width-1:0] rd,
  input logic [core_pkg::reg_addr_width-1:0] rs,
  input logic [core_pkg::reg_addr_width-1:0] rt,
  input logic [core_pkg::reg_addr_width-1:0] shamt
);
  core_pkg::instr_t ins;
  ins.r.opcode = core_pkg::op_rtype;
  ins.r.rs     = rs;
  ins.r.rt     = rt;
  ins.r.rd     = rd;
  ins.r.shamt  = shamt;
  ins.r.funct  = funct;
  return ins;
endfunction

function automatic core_pkg::instr_t encode_itype(
  input logic [5:0]                          op,
  input logic [core_pkg::reg_addr_width-1:0] dest,
  input logic [core_pkg::reg_addr_width-1:0] src,
  input logic [core_pkg::imm_width-1:0]      imm
);
  core_pkg::instr_t ins;
  ins.i.opcode = op;
  ins.i.rs     = src;
  ins.i.rt     = dest;
  ins.i.imm    = imm;
  return ins;
endfunction

// rd for register format, rt for immediates
function automatic logic [core_pkg::reg_addr_width-1:0] dest_of(input core_pkg::instr_t ins);
  if (ins.r.opcode == core_pkg::op_rtype) begin
    return ins.r.rd;
  end
  return ins.i.rt;
endfunction

function automatic logic writes_reg(input core_pkg::instr_t ins);
  logic known;
  case (ins.r.opcode)
    core_pkg::op_rtype: known = ins.r.funct inside {core_pkg::fn_add, core_pkg::fn_sub,
      core_pkg::fn_and, core_pkg::fn_or, core_pkg::fn_xor, core_pkg::fn_slt,
      core_pkg::fn_sll, core_pkg::fn_srl};
    core_pkg::op_addi, core_pkg::op_andi, core_pkg::op_ori, core_pkg::op_lui: known = 1'b1;
    default: known = 1'b0;
  endcase
  return known && (dest_of(ins) != 5'd0);
endfunction

function automatic logic [core_pkg::data_width-1:0] alu_value(
  input core_pkg::instr_t                ins,
  input logic [core_pkg::data_width-1:0] a,
  input logic [core_pkg::data_width-1:0] b
);
  logic [core_pkg::data_width-1:0] zimm;
  logic [core_pkg::data_width-1:0] res;
  zimm = {16'h0000, ins.i.imm};
  res  = '0;
  case (ins.r.opcode)
    core_pkg::op_rtype: begin
      case (ins.r.funct)
        core_pkg::fn_add: res = a + b;
        core_pkg::fn_sub: res = a - b;
        core_pkg::fn_and: res = a & b;
        core_pkg::fn_or:  res = a | b;
        core_pkg::fn_xor: res = a ^ b;
        core_pkg::fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        core_pkg::fn_sll: res = b << ins.r.shamt;
        core_pkg::fn_srl: res = b >> ins.r.shamt;
        default:          res = '0;
      endcase
    end
    core_pkg::op_addi: res = a + zimm;
    core_pkg::op_andi: res = a & zimm;
    core_pkg::op_ori:  res = a | zimm;
    core_pkg::op_lui:  res = {ins.i.imm, 16'h0000};
    default:           res = '0;
  endcase
  return res;
endfunction

// both lanes see the state before the pair, lane 1 written last
function automatic void apply_pair(
  input core_pkg::instr_t ins0,
  input core_pkg::instr_t ins1,
  input int               stamp
);
  logic [core_pkg::data_width-1:0] res0;
  logic [core_pkg::data_width-1:0] res1;
  exp_t                            e;
  res0 = alu_value(ins0, model_regs[ins0.r.rs], model_regs[ins0.r.rt]);
  res1 = alu_value(ins1, model_regs[ins1.r.rs], model_regs[ins1.r.rt]);
  e.stamp = stamp;
  if (writes_reg(ins0)) begin
    model_regs[dest_of(ins0)] = res0;
    e.rd   = dest_of(ins0);
    e.data = res0;
    exp0_q.push_back(e);
  end
  if (writes_reg(ins1)) begin
    model_regs[dest_of(ins1)] = res1;
    e.rd   = dest_of(ins1);
    e.data = res1;
    exp1_q.push_back(e);
  end
endfunction

`endif

// File: tb/core_tb.sv
`timescale 1ns/1ps

module core_tb;

  typedef struct packed {
    int                                  stamp;
    logic [core_pkg::reg_addr_width-1:0] rd;
    logic [core_pkg::data_width-1:0]     data;
  } exp_t;

  logic                                clk;
  logic                                arst_n;
  logic                                issue;
  core_pkg::instr_t                    instr0;
  core_pkg::instr_t                    instr1;
  logic                                wb0_valid;
  logic                                wb1_valid;
  logic [core_pkg::reg_addr_width-1:0] wb0_reg;
  logic [core_pkg::reg_addr_width-1:0] wb1_reg;
  logic [core_pkg::data_width-1:0]     wb0_data;
  logic [core_pkg::data_width-1:0]     wb1_data;

  // expected writes per lane, stamped with their cycle
  exp_t  exp0_q [$];
  exp_t  exp1_q [$];
  int    cycle;
  int    checks;
  int    errors;
  int    errors_at_start;
  logic  checking_on;
  string test_name;

  `include "ref_model.svh"

  dual_issue_core i_dual_issue_core (
    .clk       (clk),
    .arst_n    (arst_n),
    .issue     (issue),
    .instr0    (instr0),
    .instr1    (instr1),
    .wb0_valid (wb0_valid),
    .wb1_valid (wb1_valid),
    .wb0_reg   (wb0_reg),
    .wb1_reg   (wb1_reg),
    .wb0_data  (wb0_data),
    .wb1_data  (wb1_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////
  // checking
  ////////////////////

  task automatic compare_lane(
    input int                                  lane,
    input logic                                due,
    input exp_t                                want,
    input logic                                valid,
    input logic [core_pkg::reg_addr_width-1:0] rg,
    input logic [core_pkg::data_width-1:0]     data
  );
    checks++;
    if (due) begin
      assert (valid === 1'b1) else begin
        $display("FAIL %s lane %0d strobe: expected 1 actual %b", test_name, lane, valid);
        errors++;
      end
      assert (rg === want.rd) else begin
        $display("FAIL %s lane %0d reg: expected %0d actual %0d", test_name, lane, want.rd, rg);
        errors++;
      end
      assert (data === want.data) else begin
        $display("FAIL %s lane %0d data: expected %h actual %h", test_name, lane, want.data,
                 data);
        errors++;
      end
    end else begin
      assert (valid === 1'b0) else begin
        $display("FAIL %s lane %0d strobe: expected 0 actual %b", test_name, lane, valid);
        errors++;
      end
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin : compare_outputs
    exp_t e0;
    exp_t e1;
    logic due0;
    logic due1;
    if (checking_on) begin
      due0 = (exp0_q.size() > 0) && (exp0_q[0].stamp == cycle);
      due1 = (exp1_q.size() > 0) && (exp1_q[0].stamp == cycle);
      e0   = due0 ? exp0_q.pop_front() : '0;
      e1   = due1 ? exp1_q.pop_front() : '0;
      compare_lane(0, due0, e0, wb0_valid, wb0_reg, wb0_data);
      compare_lane(1, due1, e1, wb1_valid, wb1_reg, wb1_data);
    end
  end

  ////////////////////
  // stimulus helpers
  ////////////////////

  task automatic issue_pair(input core_pkg::instr_t a, input core_pkg::instr_t b);
    issue  = 1'b1;
    instr0 = a;
    instr1 = b;
    apply_pair(a, b, cycle + 3);
    @(posedge clk);
    #1;
    issue = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    issue = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp0_q.size() > 0 || exp1_q.size() > 0) && waited < 10) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp0_q.size() > 0 || exp1_q.size() > 0) begin
      $display("%s: expected writes never appeared on the write-back ports", test_name);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    wait_drain();
    $display("test %s: %0d errors", test_name, errors - errors_at_start);
  endtask

  function automatic logic [5:0] random_funct();
    case ($urandom_range(7, 0))
      0: return core_pkg::fn_add;
      1: return core_pkg::fn_sub;
      2: return core_pkg::fn_and;
      3: return core_pkg::fn_or;
      4: return core_pkg::fn_xor;
      5: return core_pkg::fn_slt;
      6: return core_pkg::fn_sll;
      default: return core_pkg::fn_srl;
    endcase
  endfunction

  function automatic core_pkg::instr_t random_rtype();
    return encode_rtype(random_funct(), 5'($urandom_range(31, 1)), 5'($urandom_range(31, 0)),
                        5'($urandom_range(31, 0)), 5'($urandom));
  endfunction

  function automatic core_pkg::instr_t random_itype();
    logic [5:0] op;
    case ($urandom_range(3, 0))
      0: op = core_pkg::op_addi;
      1: op = core_pkg::op_andi;
      2: op = core_pkg::op_ori;
      default: op = core_pkg::op_lui;
    endcase
    return encode_itype(op, 5'($urandom_range(31, 1)), 5'($urandom_range(31, 0)),
                        16'($urandom));
  endfunction

  // sources drawn from the previous pair's destinations
  function automatic core_pkg::instr_t forward_instr(
    input logic [4:0] p0,
    input logic [4:0] p1,
    input logic [4:0] dest
  );
    logic [4:0] a;
    logic [4:0] b;
    a = ($urandom_range(1, 0) == 1) ? p1 : p0;
    b = ($urandom_range(1, 0) == 1) ? p1 : p0;
    if ($urandom_range(1, 0) == 1) begin
      return encode_rtype(random_funct(), dest, a, b, 5'($urandom));
    end
    return encode_itype(core_pkg::op_addi, dest, a, 16'($urandom));
  endfunction

  ////////////////////
  // tests
  ////////////////////

  task automatic idle_after_reset();
    start_test("idle_after_reset");
    idle_cycles(10);
    // read every register once, all still zero
    for (int k = 0; k < 16; k++) begin
      issue_pair(encode_rtype(core_pkg::fn_or, (k == 0) ? 5'd1 : 5'(2 * k), 5'(2 * k), 5'd0, 5'd0),
                 encode_rtype(core_pkg::fn_or, 5'(2 * k + 1), 5'(2 * k + 1), 5'd0, 5'd0));
    end
    end_test();
  endtask

  task automatic immediate_ops();
    start_test("immediate_ops");
    issue_pair(encode_itype(core_pkg::op_lui, 5'd1, 5'd0, 16'h8001),
               encode_itype(core_pkg::op_ori, 5'd2, 5'd0, 16'hffff));
    issue_pair(encode_itype(core_pkg::op_addi, 5'd3, 5'd1, 16'hfffe),
               encode_itype(core_pkg::op_andi, 5'd4, 5'd1, 16'hffff));
    for (int n = 0; n < 30; n++) begin
      issue_pair(random_itype(), random_itype());
    end
    end_test();
  endtask

  task automatic register_ops();
    start_test("register_ops");
    for (int n = 0; n < 40; n++) begin
      issue_pair(random_rtype(), random_rtype());
      if ($urandom_range(3, 0) == 0) begin
        idle_cycles(1);
      end
    end
    end_test();
  endtask

  task automatic back_to_back_forwarding();
    logic [4:0] p0;
    logic [4:0] p1;
    logic [4:0] d0;
    logic [4:0] d1;
    start_test("back_to_back_forwarding");
    p0 = 5'd1;
    p1 = 5'd2;
    for (int n = 0; n < 30; n++) begin
      d0 = 5'($urandom_range(31, 1));
      d1 = 5'($urandom_range(31, 1));
      issue_pair(forward_instr(p0, p1, d0), forward_instr(p0, p1, d1));
      p0 = d0;
      p1 = d1;
    end
    end_test();
  endtask

  task automatic same_pair_hazards();
    logic [4:0] d;
    logic [4:0] x;
    logic [4:0] y;
    start_test("same_pair_hazards");
    for (int n = 0; n < 8; n++) begin
      d = 5'($urandom_range(31, 1));
      x = 5'($urandom_range(31, 1));
      y = 5'($urandom_range(31, 1));
      // lane 1 reads lane 0's destination
      issue_pair(encode_itype(core_pkg::op_addi, d, 5'($urandom_range(31, 0)), 16'($urandom)),
                 encode_rtype(core_pkg::fn_add, x, d, d, 5'd0));
      issue_pair(encode_itype(core_pkg::op_ori, d, 5'd0, 16'($urandom)),
                 encode_itype(core_pkg::op_lui, d, 5'd0, 16'($urandom)));
      issue_pair(encode_rtype(core_pkg::fn_or, x, d, 5'd0, 5'd0),
                 encode_rtype(core_pkg::fn_add, y, 5'd0, d, 5'd0));
      idle_cycles(3);
      issue_pair(encode_rtype(core_pkg::fn_or, x, d, 5'd0, 5'd0),
                 encode_rtype(core_pkg::fn_xor, y, d, 5'd0, 5'd0));
    end
    end_test();
  endtask

  task automatic discarded_writes();
    start_test("discarded_writes");
    issue_pair(encode_rtype(core_pkg::fn_add, 5'd0, 5'd3, 5'd4, 5'd0),
               encode_itype(core_pkg::op_addi, 5'd0, 5'd5, 16'h1234));
    for (int n = 0; n < 10; n++) begin
      issue_pair(encode_itype(6'($urandom_range(63, 16)), 5'($urandom_range(31, 1)),
                              5'($urandom_range(31, 0)), 16'($urandom)),
                 encode_rtype(6'($urandom_range(63, 48)), 5'($urandom_range(31, 1)),
                              5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)), 5'd0));
    end
    idle_cycles(5);
    issue_pair(encode_rtype(core_pkg::fn_or, 5'd9, 5'd0, 5'd0, 5'd0),
               encode_itype(core_pkg::op_addi, 5'd10, 5'd0, 16'hbeef));
    end_test();
  endtask

  initial begin
    void'($urandom(32'h1b89));
    arst_n      = 1'b0;
    issue       = 1'b0;
    instr0      = '0;
    instr1      = '0;
    cycle       = 0;
    checks      = 0;
    errors      = 0;
    checking_on = 1'b0;
    test_name   = "reset";
    for (int r = 0; r < core_pkg::num_regs; r++) begin
      model_regs[r] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    arst_n      = 1'b1;
    checking_on = 1'b1;

    idle_after_reset();
    immediate_ops();
    register_ops();
    back_to_back_forwarding();
    same_pair_hazards();
    discarded_writes();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+tb
logic/core_pkg.sv
logic/lane_decoder.sv
logic/register_file.sv
logic/forwarding_unit.sv
logic/execute_lane.sv
logic/dual_issue_core.sv
tb/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
